// File: include/cache_defs.svh
// cache sizing macros for address, word, line and write-through buffer widths
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// byte address and word widths
`define CACHE_ADDR_W 16
`define CACHE_DATA_W 32
`define CACHE_NBYTES_W 2
`define CACHE_NBYTES (1 << `CACHE_NBYTES_W)

// direct-mapped geometry, 16 lines of 4 words
`define CACHE_NLINES_W 4
`define CACHE_WORD_OFFSET_W 2

// word address = tag | line index | word offset
`define CACHE_WADDR_W (`CACHE_ADDR_W - `CACHE_NBYTES_W)
`define CACHE_LADDR_W (`CACHE_WADDR_W - `CACHE_WORD_OFFSET_W)
`define CACHE_TAG_W (`CACHE_LADDR_W - `CACHE_NLINES_W)

// write-through buffer holds 2**depth entries
`define CACHE_WTBUF_DEPTH_W 2

`endif

// File: list.f
+incdir+include
rtl/cache_pkg.sv
rtl/cache_front_end.sv
rtl/cache_memory.sv
rtl/cache_wtbuf.sv
rtl/cache_back_end.sv
rtl/cache_top.sv
sim/tb_clock.sv
sim/cache_checker.sv
sim/tb_cache.sv

// File: rtl/cache_back_end.sv
// cache back end: memory-bus master that drains the write-through buffer and fetches fill lines
`include "cache_defs.svh"

module cache_back_end
   import cache_pkg::*;
(
   input  logic                            clk,
   input  logic                            arst_n,
   input  wt_entry_t                       wt_head,
   input  logic                            wt_valid,
   output logic                            wt_pop,
   input  logic                            fill_req,
   input  logic [`CACHE_LADDR_W-1:0]       fill_addr,
   output logic                            fill_we,
   output logic [`CACHE_WORD_OFFSET_W-1:0] fill_word,
   output logic [`CACHE_DATA_W-1:0]        fill_data,
   output logic                            fill_done,
   output logic                            mem_req,
   output mem_req_t                        mem,
   input  logic [`CACHE_DATA_W-1:0]        mem_rdata,
   input  logic                            mem_ack
);

   be_state_t state;

   logic [`CACHE_WORD_OFFSET_W-1:0] fill_cnt;
   logic                            last_word;

   assign last_word = (fill_cnt == '1);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= BE_IDLE;
         mem_req  <= 1'b0;
         fill_cnt <= '0;
      end else begin
         unique case (state)
            BE_IDLE: begin
               // buffered writes go first
               if (wt_valid) begin
                  state   <= BE_WRITE;
                  mem_req <= 1'b1;
               end else if (fill_req) begin
                  state    <= BE_READ;
                  mem_req  <= 1'b1;
                  fill_cnt <= '0;
               end
            end
            BE_WRITE: begin
               if (mem_ack) begin
                  state   <= BE_IDLE;
                  mem_req <= 1'b0;
               end
            end
            BE_READ: begin
               if (mem_ack) begin
                  if (last_word) begin
                     state   <= BE_IDLE;
                     mem_req <= 1'b0;
                  end else begin
                     fill_cnt <= fill_cnt + 1'b1;
                  end
               end
            end
            default: state <= BE_IDLE;
         endcase
      end
   end

   // bus payload, reloaded at the start of each transfer
   always_ff @(posedge clk) begin
      if (state == BE_IDLE) begin
         if (wt_valid) begin
            mem.op    <= MEM_WRITE;
            mem.addr  <= wt_head.addr;
            mem.wdata <= wt_head.wdata;
            mem.wstrb <= wt_head.wstrb;
         end else if (fill_req) begin
            mem.op    <= MEM_READ;
            mem.addr  <= {fill_addr, {`CACHE_WORD_OFFSET_W{1'b0}}};
            mem.wdata <= '0;
            mem.wstrb <= '0;
         end
      end else if (state == BE_READ && mem_ack && !last_word) begin
         mem.addr <= {fill_addr, fill_cnt + 1'b1};
      end
   end

   // entry leaves the buffer only once memory has taken it
   assign wt_pop = (state == BE_WRITE) && mem_ack;

   assign fill_we   = (state == BE_READ) && mem_ack;
   assign fill_word = fill_cnt;
   assign fill_data = mem_rdata;
   // done comes with the last word
   assign fill_done = fill_we && last_word;

   a_bus_hold: assert property (@(posedge clk) disable iff (!arst_n)
      mem_req && !mem_ack |=> mem_req && $stable(mem));

endmodule

// File: rtl/cache_front_end.sv
// cache front end: registers the native request and returns rdata/ack
`include "cache_defs.svh"

module cache_front_end
   import cache_pkg::*;
(
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     req,
   input  logic [`CACHE_ADDR_W-1:0] addr,
   input  logic [`CACHE_DATA_W-1:0] wdata,
   input  logic [`CACHE_NBYTES-1:0] wstrb,
   output logic [`CACHE_DATA_W-1:0] rdata,
   output logic                     ack,
   output logic                     data_req,
   output cache_req_t               data_reg,
   input  logic [`CACHE_DATA_W-1:0] data_rdata,
   input  logic                     data_ack
);

   // busy from capture until the cache memory acks
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         data_req <= 1'b0;
      end else if (data_req) begin
         if (data_ack) begin
            data_req <= 1'b0;
         end
      end else if (req) begin
         data_req <= 1'b1;
      end
   end

   // byte offset dropped, the cache works on word addresses
   always_ff @(posedge clk) begin
      if (!data_req && req) begin
         data_reg.addr  <= addr[`CACHE_ADDR_W-1:`CACHE_NBYTES_W];
         data_reg.wdata <= wdata;
         data_reg.wstrb <= wstrb;
      end
   end

   assign rdata = data_rdata;
   assign ack   = data_ack;

   a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
      data_req |=> $stable(data_reg));

   // the cache memory only answers a request that is pending
   a_ack_owned: assert property (@(posedge clk) disable iff (!arst_n)
      data_ack |-> data_req);

endmodule

// File: rtl/cache_memory.sv
// cache memory: tag, valid and data arrays, hit detection, line-fill FSM and write-through issue
`include "cache_defs.svh"

module cache_memory
   import cache_pkg::*;
(
   input  logic                           clk,
   input  logic                           arst_n,
   input  logic                           data_req,
   input  cache_req_t                     data_reg,
   output logic [`CACHE_DATA_W-1:0]       data_rdata,
   output logic                           data_ack,
   input  logic                           invalidate,
   output logic                           wt_push,
   output wt_entry_t                      wt_entry,
   input  logic                           wt_full,
   input  logic                           wt_empty,
   output logic                           fill_req,
   output logic [`CACHE_LADDR_W-1:0]      fill_addr,
   input  logic                           fill_we,
   input  logic [`CACHE_WORD_OFFSET_W-1:0] fill_word,
   input  logic [`CACHE_DATA_W-1:0]       fill_data,
   input  logic                           fill_done
);

   localparam int NLINES = 1 << `CACHE_NLINES_W;
   localparam int NWORDS = 1 << (`CACHE_NLINES_W + `CACHE_WORD_OFFSET_W);

   cache_state_t state, state_nxt;

   logic [`CACHE_TAG_W-1:0]  tag_mem [NLINES];
   logic [`CACHE_DATA_W-1:0] data_mem [NWORDS];
   logic [NLINES-1:0]        valid;

   logic [`CACHE_TAG_W-1:0]         req_tag;
   logic [`CACHE_NLINES_W-1:0]      req_index;
   logic [`CACHE_WORD_OFFSET_W-1:0] req_word;
   logic                            is_write;
   logic                            hit;
   logic                            write_hit;

   // split of the word address
   assign req_tag   = data_reg.addr[`CACHE_WADDR_W-1 -: `CACHE_TAG_W];
   assign req_index = data_reg.addr[`CACHE_WORD_OFFSET_W +: `CACHE_NLINES_W];
   assign req_word  = data_reg.addr[`CACHE_WORD_OFFSET_W-1:0];
   assign is_write  = |data_reg.wstrb;

   assign hit       = valid[req_index] && (tag_mem[req_index] == req_tag);
   assign write_hit = wt_push && hit;

   always_comb begin
      state_nxt = state;
      data_ack  = 1'b0;
      wt_push   = 1'b0;
      unique case (state)
         C_IDLE: begin
            if (data_req) begin
               state_nxt = C_LOOKUP;
            end
         end
         C_LOOKUP: begin
            if (is_write) begin
               // writes stall here while the buffer is full
               if (!wt_full) begin
                  wt_push   = 1'b1;
                  data_ack  = 1'b1;
                  state_nxt = C_IDLE;
               end
            end else if (hit) begin
               data_ack  = 1'b1;
               state_nxt = C_IDLE;
            end else begin
               state_nxt = C_WAIT_WTB;
            end
         end
         C_WAIT_WTB: begin
            // pending writes must reach memory before the line is read
            if (wt_empty) begin
               state_nxt = C_FILL;
            end
         end
         C_FILL: begin
            if (fill_done) begin
               state_nxt = C_REPLY;
            end
         end
         C_REPLY: begin
            data_ack  = 1'b1;
            state_nxt = C_IDLE;
         end
         default: state_nxt = C_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state <= C_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   assign fill_req  = (state == C_FILL);
   assign fill_addr = data_reg.addr[`CACHE_WADDR_W-1:`CACHE_WORD_OFFSET_W];

   assign wt_entry.addr  = data_reg.addr;
   assign wt_entry.wdata = data_reg.wdata;
   assign wt_entry.wstrb = data_reg.wstrb;

   assign data_rdata = data_mem[{req_index, req_word}];

   // fill words arrive in order, hit writes merge under wstrb
   always_ff @(posedge clk) begin
      if (fill_we) begin
         data_mem[{req_index, fill_word}] <= fill_data;
      end else if (write_hit) begin
         for (int b = 0; b < `CACHE_NBYTES; b++) begin
            if (data_reg.wstrb[b]) begin
               data_mem[{req_index, req_word}][8*b +: 8] <= data_reg.wdata[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fill_done) begin
         tag_mem[req_index] <= req_tag;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid <= '0;
      end else if (invalidate) begin
         valid <= '0;
      end else if (fill_done) begin
         valid[req_index] <= 1'b1;
      end
   end

   a_push_room: assert property (@(posedge clk) disable iff (!arst_n)
      wt_push |-> !wt_full);

   // reads never overtake buffered writes
   a_fill_ordered: assert property (@(posedge clk) disable iff (!arst_n)
      fill_req |-> wt_empty);

endmodule

// File: rtl/cache_pkg.sv
// cache package: request, buffer-entry and memory-bus structs, FSM states and bus opcodes
`include "cache_defs.svh"

package cache_pkg;

   // registered front-end request, nonzero wstrb marks a write
   typedef struct packed {
      logic [`CACHE_WADDR_W-1:0] addr;
      logic [`CACHE_DATA_W-1:0]  wdata;
      logic [`CACHE_NBYTES-1:0]  wstrb;
   } cache_req_t;

   // one pending write-through
   typedef struct packed {
      logic [`CACHE_WADDR_W-1:0] addr;
      logic [`CACHE_DATA_W-1:0]  wdata;
      logic [`CACHE_NBYTES-1:0]  wstrb;
   } wt_entry_t;

   typedef enum logic {
      MEM_READ  = 1'b0,
      MEM_WRITE = 1'b1
   } mem_op_t;

   // word-wide memory bus request
   typedef struct packed {
      mem_op_t                   op;
      logic [`CACHE_WADDR_W-1:0] addr;
      logic [`CACHE_DATA_W-1:0]  wdata;
      logic [`CACHE_NBYTES-1:0]  wstrb;
   } mem_req_t;

   typedef enum logic [2:0] {
      C_IDLE,
      C_LOOKUP,
      C_WAIT_WTB,
      C_FILL,
      C_REPLY
   } cache_state_t;

   typedef enum logic [1:0] {
      BE_IDLE,
      BE_WRITE,
      BE_READ
   } be_state_t;

endpackage

// File: rtl/cache_top.sv
// cache top level: front end, cache memory, write-through buffer and back end
`include "cache_defs.svh"

module cache_top
   import cache_pkg::*;
(
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     req,
   input  logic [`CACHE_ADDR_W-1:0] addr,
   input  logic [`CACHE_DATA_W-1:0] wdata,
   input  logic [`CACHE_NBYTES-1:0] wstrb,
   output logic [`CACHE_DATA_W-1:0] rdata,
   output logic                     ack,
   input  logic                     invalidate,
   output logic                     wtb_empty,
   output logic                     mem_req,
   output mem_req_t                 mem,
   input  logic [`CACHE_DATA_W-1:0] mem_rdata,
   input  logic                     mem_ack
);

   // front end to cache memory
   logic                     data_req;
   cache_req_t               data_reg;
   logic [`CACHE_DATA_W-1:0] data_rdata;
   logic                     data_ack;

   // write-through path
   logic      wt_push;
   wt_entry_t wt_entry;
   logic      wt_full;
   wt_entry_t wt_head;
   logic      wt_valid;
   logic      wt_pop;

   // line fill
   logic                            fill_req;
   logic [`CACHE_LADDR_W-1:0]       fill_addr;
   logic                            fill_we;
   logic [`CACHE_WORD_OFFSET_W-1:0] fill_word;
   logic [`CACHE_DATA_W-1:0]        fill_data;
   logic                            fill_done;

   cache_front_end u_front_end (.*);

   // buffer empty flag also leaves the chip as wtb_empty
   cache_memory u_memory (
      .wt_empty (wtb_empty),
      .*
   );

   cache_wtbuf u_wtbuf (
      .wt_empty (wtb_empty),
      .*
   );

   cache_back_end u_back_end (.*);

endmodule

// File: rtl/cache_wtbuf.sv
// write-through buffer: circular FIFO of pending write entries with full and empty flags
`include "cache_defs.svh"

module cache_wtbuf
   import cache_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  logic      wt_push,
   input  wt_entry_t wt_entry,
   input  logic      wt_pop,
   output wt_entry_t wt_head,
   output logic      wt_valid,
   output logic      wt_full,
   output logic      wt_empty
);

   localparam int AW    = `CACHE_WTBUF_DEPTH_W;
   localparam int DEPTH = 1 << AW;

   wt_entry_t fifo_mem [DEPTH];

   // extra msb tells full from empty
   logic [AW:0] wr_ptr;
   logic [AW:0] rd_ptr;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wt_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (wt_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wt_push) begin
         fifo_mem[wr_ptr[AW-1:0]] <= wt_entry;
      end
   end

   assign wt_head  = fifo_mem[rd_ptr[AW-1:0]];
   assign wt_empty = (wr_ptr == rd_ptr);
   assign wt_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
   assign wt_valid = !wt_empty;

   a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
      !(wt_push && wt_full) && !(wt_pop && wt_empty));

endmodule

// File: run_sim.sh
#!/bin/sh
# build the cache testbench with Verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
   --top-module tb_cache -f list.f -o sim_cache

./obj_dir/sim_cache | tee sim.log

if grep -qx "No errors" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// File: sim/cache_checker.sv
// cache checker with reference memory, direct-mapped tag model, latency and bus-order checks
`include "cache_defs.svh"

module cache_checker
   import cache_pkg::*;
(
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     req,
   input  logic [`CACHE_ADDR_W-1:0] addr,
   input  logic [`CACHE_DATA_W-1:0] wdata,
   input  logic [`CACHE_NBYTES-1:0] wstrb,
   input  logic [`CACHE_DATA_W-1:0] rdata,
   input  logic                     ack,
   input  logic                     invalidate,
   input  logic                     wtb_empty,
   input  logic                     mem_req,
   input  mem_req_t                 mem,
   input  logic                     mem_ack,
   input  byte                      op_kind,
   input  logic [`CACHE_DATA_W-1:0] exp_rdata,
   input  logic                     run_done,
   output int                       errors,
   output int                       checks
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NLINES    = 1 << `CACHE_NLINES_W;
   localparam int WTB_DEPTH = 1 << `CACHE_WTBUF_DEPTH_W;

   // words written so far override the initial pattern
   logic [`CACHE_DATA_W-1:0] ref_mem [int];
   wt_entry_t                wr_q [$];

   logic [NLINES-1:0]       valid_m = '0;
   logic [`CACHE_TAG_W-1:0] tag_m [NLINES];

   int                        err_cnt = 0;
   int                        chk_cnt = 0;
   int                        stalls = 0;
   int                        cyc;
   int                        rd_count;
   logic                      busy = 1'b0;
   logic                      full_seen = 1'b0;
   logic                      final_done = 1'b0;
   byte                       cur_op;
   logic [`CACHE_WADDR_W-1:0] cur_wa;
   logic [`CACHE_DATA_W-1:0]  cur_wdata;
   logic [`CACHE_NBYTES-1:0]  cur_wstrb;
   logic [`CACHE_DATA_W-1:0]  cur_exp;

   assign errors = err_cnt;
   assign checks = chk_cnt;

   function automatic logic [`CACHE_DATA_W-1:0] ref_word(input logic [`CACHE_WADDR_W-1:0] wa);
      if (ref_mem.exists(int'(wa))) begin
         return ref_mem[int'(wa)];
      end
      return 32'(wa) ^ 32'h5a5a0000;
   endfunction

   task automatic report_mismatch(input string msg);
      $display("[ERROR] %0t %s", $time, msg);
      err_cnt++;
   endtask

   task automatic report_failure(input string msg);
      $display("%s", msg);
      err_cnt++;
   endtask

   // update models and compare when a request completes
   task automatic close_request();
      logic [`CACHE_NLINES_W-1:0] idx;
      logic [`CACHE_TAG_W-1:0]    tag;
      logic                       hit;
      logic [`CACHE_DATA_W-1:0]   merged;
      wt_entry_t                  ent;
      int                         exp_reads;
      idx = cur_wa[`CACHE_WORD_OFFSET_W +: `CACHE_NLINES_W];
      tag = cur_wa[`CACHE_WADDR_W-1 -: `CACHE_TAG_W];
      hit = valid_m[idx] && (tag_m[idx] == tag);
      if (cur_op == "R") begin
         chk_cnt += 2;
         if (rdata !== cur_exp) begin
            report_mismatch($sformatf("read %h gave %h, testdata expects %h",
                                      cur_wa, rdata, cur_exp));
         end
         if (rdata !== ref_word(cur_wa)) begin
            report_mismatch($sformatf("read %h gave %h, reference memory holds %h",
                                      cur_wa, rdata, ref_word(cur_wa)));
         end
         if (hit && cyc != 2) begin
            report_mismatch($sformatf("read hit %h acked after %0d cycles", cur_wa, cyc));
         end
         exp_reads = hit ? 0 : 4;
         if (!hit) begin
            valid_m[idx] = 1'b1;
            tag_m[idx]   = tag;
         end
      end else begin
         merged = ref_word(cur_wa);
         for (int b = 0; b < `CACHE_NBYTES; b++) begin
            if (cur_wstrb[b]) begin
               merged[8*b +: 8] = cur_wdata[8*b +: 8];
            end
         end
         ref_mem[int'(cur_wa)] = merged;
         ent.addr  = cur_wa;
         ent.wdata = cur_wdata;
         ent.wstrb = cur_wstrb;
         wr_q.push_back(ent);
         // a write may only wait while the buffer is full
         if (cyc < 2 || full_seen != (cyc > 2)) begin
            report_mismatch($sformatf("write %h acked after %0d cycles, buffer full %0b",
                                      cur_wa, cyc, full_seen));
         end else if (full_seen) begin
            stalls++;
         end
         exp_reads = 0;
      end
      chk_cnt++;
      if (rd_count != exp_reads) begin
         report_mismatch($sformatf("%0d bus reads for %c at %h, expected %0d",
                                   rd_count, cur_op, cur_wa, exp_reads));
      end
   endtask

   always @(negedge clk) begin : watch
      wt_entry_t ent;
      int        pending;
      if (!arst_n) begin
         if (ack !== 1'b0 || mem_req !== 1'b0 || wtb_empty !== 1'b1) begin
            report_mismatch("ack, mem_req or wtb_empty wrong during reset");
         end
      end else begin
         // acked writes not yet taken by the bus still sit in the buffer
         pending = wr_q.size();
         chk_cnt++;
         if (wtb_empty !== (pending == 0)) begin
            report_mismatch($sformatf("wtb_empty is %b with %0d writes buffered",
                                      wtb_empty, pending));
         end
         if (mem_req && mem_ack) begin
            chk_cnt++;
            if (mem.op == MEM_READ) begin
               if (!busy || cur_op != "R") begin
                  report_failure("bus read seen outside a read request");
               end else if (rd_count >= 4 ||
                            mem.addr !== {cur_wa[`CACHE_WADDR_W-1:2], 2'(rd_count)}) begin
                  report_mismatch($sformatf("fill read of %h out of line order", mem.addr));
               end
               rd_count++;
            end else if (wr_q.size() == 0) begin
               report_failure("bus write seen with no front-end write pending");
            end else begin
               ent = wr_q.pop_front();
               if (mem.addr !== ent.addr || mem.wdata !== ent.wdata ||
                   mem.wstrb !== ent.wstrb) begin
                  report_mismatch($sformatf("bus write %h/%h/%h, expected %h/%h/%h",
                                            mem.addr, mem.wdata, mem.wstrb,
                                            ent.addr, ent.wdata, ent.wstrb));
               end
            end
         end
         if (invalidate) begin
            valid_m = '0;
         end
         if (busy) begin
            cyc++;
            if (cyc >= 2 && pending == WTB_DEPTH) begin
               full_seen = 1'b1;
            end
            if (ack) begin
               busy = 1'b0;
               close_request();
            end
         end else if (ack) begin
            report_failure("ack seen with no request pending");
         end else if (req) begin
            busy      = 1'b1;
            full_seen = 1'b0;
            cyc       = 0;
            rd_count  = 0;
            cur_op    = op_kind;
            cur_wa    = addr[`CACHE_ADDR_W-1:`CACHE_NBYTES_W];
            cur_wdata = wdata;
            cur_wstrb = wstrb;
            cur_exp   = exp_rdata;
         end
         if (run_done && !final_done) begin
            final_done = 1'b1;
            if (wr_q.size() != 0) begin
               report_failure($sformatf("%0d writes never reached the bus", wr_q.size()));
            end
            if (stalls == 0) begin
               report_failure("no write was stalled by a full write-through buffer");
            end
         end
      end
   end

endmodule

// File: sim/cache_testdata.txt
# op addr wdata wstrb expected_rdata, all hex; op R read, W write, I invalidate
# expected_rdata is compared on reads only, memory starts as word_addr ^ 5a5a0000
R 0040 00000000 0 5a5a0010
R 0044 00000000 0 5a5a0011
W 0044 aabbccdd 3 00000000
R 0044 00000000 0 5a5accdd
W 0200 12345678 f 00000000
R 0200 00000000 0 12345678
W 0400 c0de0000 f 00000000
W 0404 c0de0001 f 00000000
W 0408 c0de0002 f 00000000
W 040c c0de0003 f 00000000
W 0410 c0de0004 f 00000000
W 0414 c0de0005 f 00000000
W 0418 c0de0006 f 00000000
W 041c c0de0007 f 00000000
W 0420 c0de0008 f 00000000
W 0424 c0de0009 f 00000000
R 0424 00000000 0 c0de0009
R 0420 00000000 0 c0de0008
R 0040 00000000 0 5a5a0010
I 0000 00000000 0 00000000
R 0044 00000000 0 5a5accdd

// File: sim/tb_cache.sv
// cache testbench top: testdata driver, word-wide memory-bus model and run report
`include "cache_defs.svh"

module tb_cache
   import cache_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int TIMEOUT = 200;

   logic                     clk;
   logic                     arst_n;
   logic                     req;
   logic [`CACHE_ADDR_W-1:0] addr;
   logic [`CACHE_DATA_W-1:0] wdata;
   logic [`CACHE_NBYTES-1:0] wstrb;
   logic [`CACHE_DATA_W-1:0] rdata;
   logic                     ack;
   logic                     invalidate;
   logic                     wtb_empty;
   logic                     mem_req;
   mem_req_t                 mem;
   logic [`CACHE_DATA_W-1:0] mem_rdata;
   logic                     mem_ack;

   byte                      op_kind;
   logic [`CACHE_DATA_W-1:0] exp_rdata;
   logic                     run_done;
   int                       errors;
   int                       checks;
   int                       failures;

   logic [`CACHE_DATA_W-1:0] bus_mem [1 << `CACHE_WADDR_W];
   logic [31:0]              rng_state;

   tb_clock u_clock (
      .clk    (clk),
      .arst_n (arst_n)
   );

   cache_top u_dut (.*);

   cache_checker u_checker (.*);

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // bus slave, one transfer at a time
   initial begin : bus_model
      int lat;
      mem_ack   = 1'b0;
      mem_rdata = '0;
      rng_state = 32'hf3a09ca6;
      for (int i = 0; i < (1 << `CACHE_WADDR_W); i++) begin
         bus_mem[i] = 32'(i) ^ 32'h5a5a0000;
      end
      forever begin
         @(negedge clk);
         if (arst_n && mem_req) begin
            rng_state = lcg_next(rng_state);
            // writes answered slowly so the buffer backs up
            if (mem.op == MEM_WRITE) begin
               lat = 3 + int'(rng_state[16]);
            end else begin
               lat = 1 + int'(rng_state[17:16]);
            end
            repeat (lat) @(posedge clk);
            #1;
            mem_ack = 1'b1;
            if (mem.op == MEM_WRITE) begin
               for (int b = 0; b < `CACHE_NBYTES; b++) begin
                  if (mem.wstrb[b]) begin
                     bus_mem[mem.addr][8*b +: 8] = mem.wdata[8*b +: 8];
                  end
               end
            end else begin
               mem_rdata = bus_mem[mem.addr];
            end
            @(posedge clk);
            #1;
            mem_ack = 1'b0;
         end
      end
   end

   // req stays high so the next access follows right after ack
   task automatic run_access(input byte op, input logic [15:0] a, input logic [31:0] d,
                             input logic [3:0] s, input logic [31:0] e);
      int waited;
      waited    = 0;
      op_kind   = op;
      exp_rdata = e;
      req       = 1'b1;
      addr      = a;
      wdata     = d;
      wstrb     = (op == "W") ? s : 4'h0;
      @(negedge clk);
      while (!ack && waited < TIMEOUT) begin
         waited++;
         @(negedge clk);
      end
      if (!ack) begin
         $display("timeout: no ack within %0d cycles for %c at address %h", TIMEOUT, op, a);
         failures++;
      end
      @(posedge clk);
      #1;
   endtask

   task automatic pulse_invalidate();
      req        = 1'b0;
      invalidate = 1'b1;
      @(posedge clk);
      #1;
      invalidate = 1'b0;
   endtask

   initial begin : stimulus
      int          fd;
      int          n;
      int          waited;
      string       line;
      byte         op;
      logic [15:0] a;
      logic [31:0] d;
      logic [3:0]  s;
      logic [31:0] e;
      req        = 1'b0;
      addr       = '0;
      wdata      = '0;
      wstrb      = '0;
      invalidate = 1'b0;
      op_kind    = "-";
      exp_rdata  = '0;
      run_done   = 1'b0;
      failures   = 0;
      waited     = 0;
      @(posedge clk);
      while (arst_n !== 1'b1 && waited < TIMEOUT) begin
         waited++;
         @(posedge clk);
      end
      if (arst_n !== 1'b1) begin
         $display("reset was never released");
         failures++;
      end
      @(posedge clk);
      #1;
      fd = $fopen("sim/cache_testdata.txt", "r");
      if (fd == 0) begin
         $display("cannot open sim/cache_testdata.txt");
         failures++;
      end
      while (fd != 0 && failures == 0 && !$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 0 && line.len() > 1 && line[0] != "#") begin
            n = $sscanf(line, "%c %h %h %h %h", op, a, d, s, e);
            if (n != 5) begin
               $display("malformed testdata line: %s", line);
               failures++;
            end else if (op == "I") begin
               pulse_invalidate();
            end else begin
               run_access(op, a, d, s, e);
            end
         end
      end
      if (fd != 0) begin
         $fclose(fd);
      end
      req    = 1'b0;
      waited = 0;
      while ((!wtb_empty || mem_req) && waited < TIMEOUT) begin
         waited++;
         @(negedge clk);
      end
      if (!wtb_empty || mem_req) begin
         $display("timeout: write-through buffer did not drain");
         failures++;
      end
      run_done = 1'b1;
      repeat (2) @(negedge clk);
      $display("checks %0d, errors %0d, other failures %0d", checks, errors, failures);
      if (errors == 0 && failures == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// File: sim/tb_clock.sv
// testbench clock source with a 10 ns period and a 16-cycle active-low reset
module tb_clock (
   output logic clk,
   output logic arst_n
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // release just after a rising edge
   initial begin
      arst_n = 1'b0;
      repeat (16) @(posedge clk);
      #1;
      arst_n = 1'b1;
   end

endmodule
